// ==== design/fetch_dec_reg.sv ====
module fetch_dec_reg import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   i_flush,
    input  logic   i_stall,
    input  word_t  i_mem_data,
    fetch_pc_if.rd  pc_bus,
    irq_ctx_if.rd   irq,
    output word_t  o_fetch_insn,
    output word_t  o_instruction_dec,
    output addr_t  o_pc_curr_dec,
    output addr_t  o_pc_next_dec
);

    word_t fe_q;
    word_t insn_fe;
    logic  flush_ok;
    logic  squash_fe;
    cnt_t  flush_cnt;
    addr_t pc_curr_q0;
    addr_t pc_curr_q1;
    addr_t pc_next_q0;
    addr_t pc_next_q1;

    // Flush inside the handler is ignored
    assign flush_ok = i_flush && !irq.in_handler;

    // Fetch register behind the memory
    // Memory output is frozen through a stall so this word holds
    // during the stall and the cycle after it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fe_q <= '0;
        end else if (!pc_bus.hold && !i_stall) begin
            fe_q <= i_mem_data;
        end
    end

    // NOP substitution on the fetch-side word
    assign squash_fe = (fe_q == '0) || !pc_bus.fetch_en || flush_ok ||
                       (flush_cnt != '0) || irq.squash;
    assign insn_fe = squash_fe ? NOP_INSN : fe_q;
    assign o_fetch_insn = insn_fe;

    // Extra NOP cycles after a flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_cnt <= '0;
        end else if (flush_ok) begin
            flush_cnt <= cnt_t'(FLUSH_NOPS);
        end else begin
            flush_cnt <= cnt_step(flush_cnt);
        end
    end

    // Decode instruction register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_instruction_dec <= NOP_INSN;
        end else if (flush_ok) begin
            o_instruction_dec <= NOP_INSN;
        end else if ((flush_cnt == '0) && !pc_bus.hold) begin
            o_instruction_dec <= insn_fe;
        end
    end

    // PC delay chain
    // Two stages ahead of the output keep the PCs lined up with the word
    always_ff @(posedge clk) begin
        if (!rst_n || flush_ok) begin
            pc_curr_q0 <= '0;
            pc_curr_q1 <= '0;
            pc_next_q0 <= '0;
            pc_next_q1 <= '0;
            o_pc_curr_dec <= '0;
            o_pc_next_dec <= '0;
        end else if (flush_cnt != '0) begin
            // Redirected PCs keep moving behind zeroed outputs
            pc_curr_q0 <= pc_bus.pc;
            pc_curr_q1 <= pc_curr_q0;
            pc_next_q0 <= pc_bus.pc_seq;
            pc_next_q1 <= pc_next_q0;
            o_pc_curr_dec <= '0;
            o_pc_next_dec <= '0;
        end else if (!pc_bus.hold) begin
            pc_curr_q0 <= pc_bus.pc;
            pc_curr_q1 <= pc_curr_q0;
            pc_next_q0 <= pc_bus.pc_seq;
            pc_next_q1 <= pc_next_q0;
            o_pc_curr_dec <= pc_curr_q1;
            o_pc_next_dec <= pc_next_q1;
        end
    end

endmodule

// ==== design/fetch_pc_if.sv ====
interface fetch_pc_if import fetch_pkg::*; ();

    // PC of the word being read from memory
    addr_t pc;
    // Sequential successor of pc
    addr_t pc_seq;
    // Pipeline freeze during stall or warmup
    logic hold;
    // Low only in the warmup cycle after reset
    logic fetch_en;

    // PC unit side
    modport drv (
        output pc,
        output pc_seq,
        output hold,
        output fetch_en
    );

    // Memory, interrupt unit and decode register side
    modport rd (
        input pc,
        input pc_seq,
        input hold,
        input fetch_en
    );

endinterface

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

    // Instruction and data word
    typedef logic [31:0] word_t;
    // Byte address or PC
    typedef logic [31:0] addr_t;
    // Major opcode field of an instruction
    typedef logic [6:0] opcode_t;
    // Squash and window down-counters
    typedef logic [1:0] cnt_t;

    // Instruction memory geometry
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW = 8;
    typedef logic [IMEM_AW-1:0] imem_idx_t;

    // addi x0,x0,0
    localparam word_t NOP_INSN = 32'h0000_0013;
    localparam addr_t IRQ_VECTOR = 32'h0000_0004;
    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam int PC_STEP = 4;

    // Extra squash cycles after a flush edge
    localparam int FLUSH_NOPS = 2;
    // Decode NOPs after an interrupt
    localparam int IRQ_NOPS = 2;
    // Cycles in which a branch retargets the return PC
    localparam int IRQ_WINDOW = 3;

    // Conditional branch and jalr opcodes
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JALR = 7'b110_0111;

    // Down-count that stops at zero
    function automatic cnt_t cnt_step(input cnt_t cnt);
        return (cnt != '0) ? cnt - 1'b1 : cnt;
    endfunction

endpackage

// ==== design/fetch_top.sv ====
module fetch_top import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_branch,
    input  logic  i_rti,
    input  logic  i_rsi,
    input  logic  i_interrupt,
    input  logic  i_flush,
    input  logic  i_stall,
    input  logic  i_irq_branch_alert,
    input  addr_t i_pc_ex,
    input  logic  i_ld_en,
    input  addr_t i_ld_addr,
    input  word_t i_ld_data,
    output word_t o_instruction_dec,
    output addr_t o_pc_curr_dec,
    output addr_t o_pc_next_dec
);

    word_t mem_data;
    word_t fetch_insn;

    fetch_pc_if pc_bus ();
    irq_ctx_if  irq ();

    // Reads stop while the pipeline is frozen
    imem imem_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rd_en   (~pc_bus.hold),
        .i_rd_addr (pc_bus.pc),
        .o_rd_data (mem_data),
        .i_ld_en   (i_ld_en),
        .i_ld_addr (i_ld_addr),
        .i_ld_data (i_ld_data)
    );

    pc_ctrl pc_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_branch    (i_branch),
        .i_pc_ex     (i_pc_ex),
        .i_interrupt (i_interrupt),
        .i_rti       (i_rti),
        .i_rsi       (i_rsi),
        .i_stall     (i_stall),
        .pc_bus      (pc_bus),
        .irq         (irq)
    );

    irq_return irq_return_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_interrupt        (i_interrupt),
        .i_rti              (i_rti),
        .i_rsi              (i_rsi),
        .i_stall            (i_stall),
        .i_branch           (i_branch),
        .i_irq_branch_alert (i_irq_branch_alert),
        .i_pc_ex            (i_pc_ex),
        .i_fetch_insn       (fetch_insn),
        .pc_bus             (pc_bus),
        .irq                (irq)
    );

    fetch_dec_reg fetch_dec_reg_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_flush           (i_flush),
        .i_stall           (i_stall),
        .i_mem_data        (mem_data),
        .pc_bus            (pc_bus),
        .irq               (irq),
        .o_fetch_insn      (fetch_insn),
        .o_instruction_dec (o_instruction_dec),
        .o_pc_curr_dec     (o_pc_curr_dec),
        .o_pc_next_dec     (o_pc_next_dec)
    );

endmodule

// ==== design/imem.sv ====
module imem import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_rd_en,
    input  addr_t i_rd_addr,
    output word_t o_rd_data,
    input  logic  i_ld_en,
    input  addr_t i_ld_addr,
    input  word_t i_ld_data
);

    word_t mem [IMEM_WORDS];

    imem_idx_t rd_idx;
    imem_idx_t ld_idx;

    // Word index from byte address
    assign rd_idx = i_rd_addr[IMEM_AW+1:2];
    assign ld_idx = i_ld_addr[IMEM_AW+1:2];

    // Load port
    // Works in and out of reset so a program can go in early
    always_ff @(posedge clk) begin
        if (i_ld_en) begin
            mem[ld_idx] <= i_ld_data;
        end
    end

    // Synchronous read
    // Output register freezes while the read enable is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Zero word comes out of fetch as a NOP
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[rd_idx];
        end
    end

endmodule

// ==== design/irq_ctx_if.sv ====
interface irq_ctx_if import fetch_pkg::*; ();

    // Where rti resumes
    addr_t ret_pc;
    // Interrupt taken and handler state still live
    logic in_handler;
    // Decode gets NOPs while set
    logic squash;
    // Branch capture window still open
    logic window;

    // Interrupt unit side
    modport drv (
        output ret_pc,
        output in_handler,
        output squash,
        output window
    );

    // PC unit and decode register side
    modport rd (
        input ret_pc,
        input in_handler,
        input squash,
        input window
    );

endinterface

// ==== design/irq_return.sv ====
module irq_return import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   i_interrupt,
    input  logic   i_rti,
    input  logic   i_rsi,
    input  logic   i_stall,
    input  logic   i_branch,
    input  logic   i_irq_branch_alert,
    input  addr_t  i_pc_ex,
    input  word_t  i_fetch_insn,
    fetch_pc_if.rd  pc_bus,
    irq_ctx_if.drv  irq
);

    addr_t   ret_pc_q;
    addr_t   ret_capture;
    logic    in_handler_q;
    logic    branch_d;
    logic    branch_in_fetch;
    opcode_t fetch_opc;
    cnt_t    squash_cnt;
    cnt_t    window_cnt;

    // Branch or jalr sitting in fetch right now
    assign fetch_opc = i_fetch_insn[6:0];
    assign branch_in_fetch = (fetch_opc == OPC_BRANCH) || (fetch_opc == OPC_JALR);

    // Return PC picked at the interrupt edge
    always_comb begin
        if (i_branch) begin
            ret_capture = i_pc_ex;
        end else if (branch_d) begin
            // Branch target already in the PC register
            ret_capture = pc_bus.pc;
        end else begin
            // First fetched word that the squash throws away
            ret_capture = pc_bus.pc - addr_t'(PC_STEP);
        end
    end

    // Return register and handler flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_pc_q <= '0;
            in_handler_q <= 1'b0;
        end else if (i_rti || i_rsi) begin
            // Handler done so the saved PC is spent
            ret_pc_q <= '0;
        end else if (!i_stall) begin
            if (i_interrupt) begin
                ret_pc_q <= ret_capture;
                in_handler_q <= 1'b1;
            end else if (irq.window && in_handler_q &&
                         (i_branch || i_irq_branch_alert || branch_in_fetch)) begin
                // Late branch from the old stream retargets the return
                if (i_branch) begin
                    ret_pc_q <= i_pc_ex;
                end
            end else begin
                in_handler_q <= 1'b0;
            end
        end
    end

    // Squash and window counters plus last-cycle branch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            squash_cnt <= '0;
            window_cnt <= '0;
            branch_d <= 1'b0;
        end else begin
            branch_d <= i_branch;
            if (i_interrupt) begin
                squash_cnt <= cnt_t'(IRQ_NOPS);
                window_cnt <= cnt_t'(IRQ_WINDOW);
            end else begin
                squash_cnt <= cnt_step(squash_cnt);
                window_cnt <= cnt_step(window_cnt);
            end
        end
    end

    assign irq.ret_pc = ret_pc_q;
    assign irq.in_handler = in_handler_q;
    assign irq.squash = (squash_cnt != '0);
    assign irq.window = (window_cnt != '0);

endmodule

// ==== design/pc_ctrl.sv ====
module pc_ctrl import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   i_branch,
    input  addr_t  i_pc_ex,
    input  logic   i_interrupt,
    input  logic   i_rti,
    input  logic   i_rsi,
    input  logic   i_stall,
    fetch_pc_if.drv pc_bus,
    irq_ctx_if.rd   irq
);

    addr_t pc_q;
    addr_t pc_seq;
    addr_t pc_next;
    logic  warmup;
    logic  hold;

    assign pc_seq = pc_q + addr_t'(PC_STEP);
    assign hold = i_stall | warmup;

    // Next PC
    // Interrupt wins over returns, handler state and branches
    always_comb begin
        if (i_interrupt) begin
            pc_next = IRQ_VECTOR;
        end else if (i_rti) begin
            // Back to the interrupted stream
            pc_next = irq.ret_pc;
        end else if (i_rsi) begin
            // Execute tells where the handler continues
            pc_next = i_pc_ex;
        end else if (irq.in_handler) begin
            // Branches here go to the return register instead
            pc_next = pc_seq;
        end else if (i_branch) begin
            pc_next = i_pc_ex;
        end else begin
            pc_next = pc_seq;
        end
    end

    // One cycle of warmup after reset
    // PC and memory stay put during it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            warmup <= 1'b1;
        end else begin
            warmup <= 1'b0;
        end
    end

    // PC register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (!hold) begin
            pc_q <= pc_next;
        end
    end

    assign pc_bus.pc = pc_q;
    assign pc_bus.pc_seq = pc_seq;
    assign pc_bus.hold = hold;
    assign pc_bus.fetch_en = ~warmup;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_tb -f vlog.f -o fetch_tb_sim

out=$(./obj_dir/fetch_tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// ==== testbench/fetch_tb_vectors.svh ====
`ifndef FETCH_TB_VECTORS_SVH
`define FETCH_TB_VECTORS_SVH

// Each row holds the repeat count in [47:40], control bits in [39:32] and i_pc_ex in [31:0]
// Control bit 6 is stall, 5 flush, 4 branch, 3 interrupt, 2 rti, 1 rsi and 0 branch alert
typedef logic [47:0] row_t;

localparam logic [7:0] CTL_IDLE = 8'h00;
localparam logic [7:0] CTL_STALL = 8'h40;
localparam logic [7:0] CTL_FLUSH = 8'h20;
localparam logic [7:0] CTL_BRANCH = 8'h10;
localparam logic [7:0] CTL_IRQ = 8'h08;
localparam logic [7:0] CTL_RTI = 8'h04;
localparam logic [7:0] CTL_RSI = 8'h02;
localparam logic [7:0] CTL_ALERT = 8'h01;

// Program loaded at address 0 with the handler entry at word 1
localparam int PROG_WORDS = 16;
localparam word_t PROG [PROG_WORDS] = '{
    32'h0010_0093, 32'h0020_0113, 32'h0000_0000, 32'h0030_8193,
    32'h0041_0213, 32'h0051_8293, 32'h0062_0313, 32'h0020_8463,
    32'h0073_0393, 32'h0083_8413, 32'h0094_0493, 32'h00a4_8513,
    32'h00b5_0593, 32'h00c5_8613, 32'h0000_80e7, 32'h00d6_0693
};

localparam int N_ROWS = 24;
localparam row_t ROWS [N_ROWS] = '{
    {8'd6, CTL_IDLE, 32'h0},
    // Branch with flush, then stall in straight-line code
    {8'd1, CTL_BRANCH | CTL_FLUSH, 32'h0000_0008},
    {8'd4, CTL_IDLE, 32'h0},
    {8'd3, CTL_STALL, 32'h0},
    {8'd3, CTL_IDLE, 32'h0},
    // Interrupt and rti to the interrupted stream
    {8'd1, CTL_IRQ, 32'h0},
    {8'd4, CTL_IDLE, 32'h0},
    {8'd1, CTL_RTI, 32'h0},
    {8'd3, CTL_IDLE, 32'h0},
    // Alert keeps the handler live so a later branch in the window retargets the return
    {8'd1, CTL_IRQ, 32'h0},
    {8'd1, CTL_ALERT, 32'h0},
    {8'd1, CTL_BRANCH, 32'h0000_0010},
    {8'd2, CTL_IDLE, 32'h0},
    {8'd1, CTL_RTI, 32'h0},
    {8'd2, CTL_IDLE, 32'h0},
    // rsi, an rti that finds the return register empty, then a fresh capture after a branch
    {8'd1, CTL_IRQ, 32'h0},
    {8'd2, CTL_IDLE, 32'h0},
    {8'd1, CTL_RSI, 32'h0000_0028},
    {8'd1, CTL_RTI, 32'h0},
    {8'd1, CTL_BRANCH, 32'h0000_0014},
    {8'd1, CTL_IRQ, 32'h0},
    {8'd2, CTL_IDLE, 32'h0},
    {8'd1, CTL_RTI, 32'h0},
    {8'd4, CTL_IDLE, 32'h0}
};

`endif

// ==== testbench/fetch_tb.sv ====
module fetch_tb import fetch_pkg::*; ();

    `include "fetch_tb_vectors.svh"

    localparam int RESET_CYCLES = 16;

    logic  clk;
    logic  rst_n;
    logic  i_branch;
    logic  i_rti;
    logic  i_rsi;
    logic  i_interrupt;
    logic  i_flush;
    logic  i_stall;
    logic  i_irq_branch_alert;
    addr_t i_pc_ex;
    logic  i_ld_en;
    addr_t i_ld_addr;
    word_t i_ld_data;
    word_t o_instruction_dec;
    addr_t o_pc_curr_dec;
    addr_t o_pc_next_dec;

    // Reference model state
    addr_t m_pc;
    logic  m_warm;
    // Memory output and fetch-side registers
    word_t m_rd;
    word_t m_fe;
    int    m_flush_cnt;
    int    m_squash_cnt;
    int    m_window_cnt;
    logic  m_branch_d;
    addr_t m_ret;
    logic  m_handler;
    addr_t m_pc_pipe [2];
    addr_t m_seq_pipe [2];
    word_t exp_insn;
    addr_t exp_pc_curr;
    addr_t exp_pc_next;

    int errors;
    int checks;

    fetch_top fetch_top_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_branch           (i_branch),
        .i_rti              (i_rti),
        .i_rsi              (i_rsi),
        .i_interrupt        (i_interrupt),
        .i_flush            (i_flush),
        .i_stall            (i_stall),
        .i_irq_branch_alert (i_irq_branch_alert),
        .i_pc_ex            (i_pc_ex),
        .i_ld_en            (i_ld_en),
        .i_ld_addr          (i_ld_addr),
        .i_ld_data          (i_ld_data),
        .o_instruction_dec  (o_instruction_dec),
        .o_pc_curr_dec      (o_pc_curr_dec),
        .o_pc_next_dec      (o_pc_next_dec)
    );

    always #4 clk = ~clk;

    // Cycles the whole table takes
    function automatic int table_cycles();
        int sum;
        sum = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            sum += int'(ROWS[r][47:40]);
        end
        return sum;
    endfunction

    // One clock edge of the fetch rules, all terms from pre-edge state
    task automatic model_step();
        logic  hold;
        logic  flush_ok;
        logic  squash;
        logic  branch_fe;
        word_t fe_word;
        addr_t pc_nxt;
        addr_t ret_cap;
        int    idx;
        if (!rst_n) begin
            m_pc = RESET_PC;
            m_warm = 1'b1;
            m_rd = '0;
            m_fe = '0;
            m_flush_cnt = 0;
            m_squash_cnt = 0;
            m_window_cnt = 0;
            m_branch_d = 1'b0;
            m_ret = '0;
            m_handler = 1'b0;
            m_pc_pipe = '{default: '0};
            m_seq_pipe = '{default: '0};
            exp_insn = NOP_INSN;
            exp_pc_curr = '0;
            exp_pc_next = '0;
            return;
        end
        hold = i_stall || m_warm;
        // Flush is ignored while the handler state is live
        flush_ok = i_flush && !m_handler;
        squash = (m_fe == '0) || m_warm || flush_ok || (m_flush_cnt != 0) ||
                 (m_squash_cnt != 0);
        fe_word = squash ? NOP_INSN : m_fe;
        branch_fe = fe_word[6:0] inside {OPC_BRANCH, OPC_JALR};
        // Next PC in priority order
        if (i_interrupt) begin
            pc_nxt = IRQ_VECTOR;
        end else if (i_rti) begin
            pc_nxt = m_ret;
        end else if (i_rsi) begin
            pc_nxt = i_pc_ex;
        end else if (i_branch && !m_handler) begin
            pc_nxt = i_pc_ex;
        end else begin
            pc_nxt = m_pc + addr_t'(PC_STEP);
        end
        if (i_branch) begin
            ret_cap = i_pc_ex;
        end else if (m_branch_d) begin
            ret_cap = m_pc;
        end else begin
            ret_cap = m_pc - addr_t'(PC_STEP);
        end
        // Decode instruction
        if (flush_ok) begin
            exp_insn = NOP_INSN;
        end else if (m_flush_cnt == 0 && !hold) begin
            exp_insn = fe_word;
        end
        // PC outputs trail the PC by two stages
        if (flush_ok) begin
            m_pc_pipe = '{default: '0};
            m_seq_pipe = '{default: '0};
            exp_pc_curr = '0;
            exp_pc_next = '0;
        end else if (m_flush_cnt != 0 || !hold) begin
            exp_pc_curr = (m_flush_cnt != 0) ? '0 : m_pc_pipe[1];
            exp_pc_next = (m_flush_cnt != 0) ? '0 : m_seq_pipe[1];
            m_pc_pipe[1] = m_pc_pipe[0];
            m_seq_pipe[1] = m_seq_pipe[0];
            m_pc_pipe[0] = m_pc;
            m_seq_pipe[0] = m_pc + addr_t'(PC_STEP);
        end
        // Return register and handler flag
        if (i_rti || i_rsi) begin
            m_ret = '0;
        end else if (!i_stall) begin
            if (i_interrupt) begin
                m_ret = ret_cap;
                m_handler = 1'b1;
            end else if (m_window_cnt != 0 && m_handler &&
                         (i_branch || i_irq_branch_alert || branch_fe)) begin
                if (i_branch) begin
                    m_ret = i_pc_ex;
                end
            end else begin
                m_handler = 1'b0;
            end
        end
        m_flush_cnt = flush_ok ? FLUSH_NOPS : ((m_flush_cnt > 0) ? m_flush_cnt - 1 : 0);
        if (i_interrupt) begin
            m_squash_cnt = IRQ_NOPS;
            m_window_cnt = IRQ_WINDOW;
        end else begin
            m_squash_cnt = (m_squash_cnt > 0) ? m_squash_cnt - 1 : 0;
            m_window_cnt = (m_window_cnt > 0) ? m_window_cnt - 1 : 0;
        end
        m_branch_d = i_branch;
        // Memory read and fetch register move only outside hold
        if (!hold) begin
            idx = int'(m_pc >> 2);
            assert (idx < PROG_WORDS) else begin
                $display("Fetch went past the loaded program at PC %h", m_pc);
                errors++;
            end
            m_fe = m_rd;
            m_rd = (idx < PROG_WORDS) ? PROG[idx] : '0;
            m_pc = pc_nxt;
        end
        m_warm = 1'b0;
    endtask

    task automatic apply_row(input row_t row);
        i_stall <= row[38];
        i_flush <= row[37];
        i_branch <= row[36];
        i_interrupt <= row[35];
        i_rti <= row[34];
        i_rsi <= row[33];
        i_irq_branch_alert <= row[32];
        i_pc_ex <= row[31:0];
        // Load port idle once the program is in
        i_ld_en <= 1'b0;
    endtask

    task automatic check_outputs();
        checks++;
        assert (o_instruction_dec === exp_insn) else begin
            $display("Fail o_instruction_dec: got %h expected %h", o_instruction_dec, exp_insn);
            errors++;
        end
        assert (o_pc_curr_dec === exp_pc_curr) else begin
            $display("Fail o_pc_curr_dec: got %h expected %h", o_pc_curr_dec, exp_pc_curr);
            errors++;
        end
        assert (o_pc_next_dec === exp_pc_next) else begin
            $display("Fail o_pc_next_dec: got %h expected %h", o_pc_next_dec, exp_pc_next);
            errors++;
        end
    endtask

    initial begin
        int limit;
        limit = (RESET_CYCLES + table_cycles() + 64) * 8;
        #(limit);
        $display("Timeout after %0d time units, table did not finish", limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        row_t row;
        clk = 1'b0;
        rst_n = 1'b0;
        i_branch = 1'b0;
        i_rti = 1'b0;
        i_rsi = 1'b0;
        i_interrupt = 1'b0;
        i_flush = 1'b0;
        i_stall = 1'b0;
        i_irq_branch_alert = 1'b0;
        i_pc_ex = '0;
        i_ld_en = 1'b0;
        i_ld_addr = '0;
        i_ld_data = '0;
        errors = 0;
        checks = 0;

        // Program goes in one word per cycle under reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            model_step();
            i_ld_en <= (i < PROG_WORDS);
            i_ld_addr <= addr_t'(i * 4);
            i_ld_data <= (i < PROG_WORDS) ? PROG[i] : '0;
            if (i == RESET_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
        end

        // Each row repeats for its count, checked mid-cycle
        for (int r = 0; r < N_ROWS; r++) begin
            row = ROWS[r];
            for (int k = 0; k < int'(row[47:40]); k++) begin
                @(posedge clk);
                model_step();
                apply_row(row);
                @(negedge clk);
                check_outputs();
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+testbench
design/fetch_pkg.sv
design/fetch_pc_if.sv
design/irq_ctx_if.sv
design/imem.sv
design/pc_ctrl.sv
design/irq_return.sv
design/fetch_dec_reg.sv
design/fetch_top.sv
testbench/fetch_tb.sv
